//--- filelist.f
verilog/ads5296_pkg.sv
verilog/ads5296_ifs.sv
verilog/ads5296_clk_monitor.sv
verilog/wb_ads5296_attach.sv
verilog/ads5296_strobe_shaper.sv
verilog/ads5296_ctrl_top.sv
bench/ads5296_asserts.sv
bench/ads5296_tb.sv

//--- Makefile
# Verilator build and run for the ADS5296 control subsystem

VERILATOR ?= verilator
TOP       ?= ads5296_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^Done: no errors$$' $(LOG) || { echo "simulation FAILED"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/ads5296_tb.sv
`timescale 1ns/1ps

module ads5296_tb import ads5296_pkg::*; ();

  localparam int NUM_UNITS  = 4;
  localparam int NUM_FCLKS  = 2;
  localparam int IS_MASTER  = 1;
  localparam int LW         = 8 * NUM_UNITS;        // lane bits in the lo word
  localparam int DW         = LW + NUM_FCLKS + 1;   // + frame clocks + sync lane
  localparam int SW         = 4 * NUM_UNITS;
  localparam int NUM_RT     = 200;                  // round-trip writes
  localparam int NUM_PULSE  = 60;
  localparam int NUM_FRAMES = 40;
  localparam int PLANNED_TX = 17 + 2 * NUM_RT + NUM_PULSE + 3 * NUM_FRAMES + 5;
  localparam longint TIMEOUT_NS = (longint'(PLANNED_TX) * 40 + 2000) * 100;

  logic                 wb_clk_i = 1'b0;
  logic                 wb_rst_i;
  logic [31:0]          wb_adr_i;
  logic [31:0]          wb_dat_i;
  logic [3:0]           wb_sel_i;
  logic                 wb_we_i;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic [31:0]          wb_dat_o;
  logic                 wb_ack_o;
  logic                 wb_err_o;
  logic                 lclk_i;
  logic [NUM_FCLKS-1:0] fclk_i;
  logic                 mmcm_locked_i;
  logic [DW-1:0]        delay_load_o;
  logic [DW-1:0]        delay_rst_o;
  logic [DW-1:0]        delay_en_vtc_o;
  logic [DLY_VAL_W-1:0] delay_val_o;
  logic [SW-1:0]        bitslip_o;
  logic                 iserdes_rst_o;
  logic                 mmcm_rst_o;
  logic                 mmcm_clksel_o;
  logic                 snapshot_trigger_o;

  // reference model
  logic [31:0] shadow [32];          // register map as the bus sees it
  cnt_t        exp_lclk;
  cnt_t        exp_fclk [NUM_FCLKS];
  cnt_t        exp_err;
  bit          frame_seen;           // first fclk0 edge opens a frame only
  int          load_exp [DW];
  int          load_seen [DW];
  int          slip_exp [SW];
  int          slip_seen [SW];
  int          val_errs;
  int          other_errs;

  ads5296_ctrl_top #(
    .NUM_UNITS(NUM_UNITS), .NUM_FCLKS(NUM_FCLKS), .IS_MASTER(IS_MASTER), .LCLK_PER_FCLK(4)
  ) dut_i (.*);

  always #50 wb_clk_i = ~wb_clk_i;

  // count pulses mid-cycle where the outputs are settled
  always @(negedge wb_clk_i) begin
    if (!wb_rst_i) begin
      for (int i = 0; i < DW; i++) begin
        if (delay_load_o[i]) load_seen[i]++;
      end
      for (int i = 0; i < SW; i++) begin
        if (bitslip_o[i]) slip_seen[i]++;
      end
    end
  end

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      val_errs++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
    if (act !== exp) begin
      val_errs++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_pulses(input string name, input int idx, input int exp, input int act);
    if (act != exp) begin
      val_errs++;
      $display("Fail %s[%0d] pulse count: expected %h, got %h", name, idx, exp, act);
    end
  endtask

  // one wishbone transfer from falling edge to falling edge
  task automatic bus_cycle(input logic [4:0] a, input logic we, input logic [31:0] d,
                           output logic [31:0] q);
    int n;
    wb_adr_i = {25'b0, a, 2'b00};
    wb_dat_i = d;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    n = 0;
    do begin
      @(negedge wb_clk_i);
      n++;
    end while (!wb_ack_o && n < 20);
    q = wb_dat_o;  // valid only with ack
    if (!wb_ack_o) begin
      other_errs++;
      $display("no ack from the bus within 20 cycles at word address %0d", a);
    end else begin
      check_word("wb_err_o", 32'h0, 32'(wb_err_o));  // no error responses at all
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic bus_write(input logic [4:0] a, input logic [31:0] d);
    logic [31:0] q;
    bus_cycle(a, 1'b1, d, q);
  endtask

  task automatic bus_read(input logic [4:0] a, output logic [31:0] q);
    bus_cycle(a, 1'b0, $urandom(), q);  // write data must be ignored
  endtask

  // writable bits per word
  function automatic logic [31:0] write_mask(input logic [4:0] a);
    case (a)
      5'd0, 5'd2, 5'd4: return 32'hffff_ffff;
      5'd1, 5'd3, 5'd5: return 32'h7;      // 2 frame clocks + sync
      5'd6:             return 32'h1ff;
      5'd8, 5'd16:      return 32'h1;
      5'd9:             return 32'h101;    // rst and clksel
      5'd15:            return 32'hffff;
      default:          return 32'h0;      // status or unmapped
    endcase
  endfunction

  task automatic apply_write(input logic [4:0] a, input logic [31:0] d);
    logic [31:0] nv;
    logic [31:0] rise;
    nv   = d & write_mask(a);
    rise = nv & ~shadow[a];
    if (a == 5'd0) begin
      for (int i = 0; i < LW; i++) load_exp[i] += int'(rise[i]);
    end
    if (a == 5'd1) begin
      for (int i = 0; i < DW - LW; i++) load_exp[LW + i] += int'(rise[i]);
    end
    if (a == 5'd15) begin
      for (int i = 0; i < SW; i++) slip_exp[i] += int'(rise[i]);
    end
    shadow[a] = nv;
  endtask

  function automatic logic [31:0] expect_read(input logic [4:0] a);
    case (a)
      5'd7:    return exp_err;
      5'd9:    return shadow[9] | (32'(mmcm_locked_i) << 16) | (32'(IS_MASTER) << 24);
      5'd10:   return exp_lclk;
      5'd11:   return exp_fclk[0];
      5'd12:   return exp_fclk[1];
      default: return shadow[a];  // fclk2/3 and unmapped stay zero
    endcase
  endfunction

  task automatic check_levels();
    repeat (2) @(negedge wb_clk_i);  // shaper adds one flop
    check_word("delay_rst_o lo", shadow[2], delay_rst_o[LW-1:0]);
    check_word("delay_rst_o hi", shadow[3], 32'(delay_rst_o[DW-1:LW]));
    check_word("delay_en_vtc_o lo", shadow[4], delay_en_vtc_o[LW-1:0]);
    check_word("delay_en_vtc_o hi", shadow[5], 32'(delay_en_vtc_o[DW-1:LW]));
    check_word("delay_val_o", shadow[6], 32'(delay_val_o));
    check_word("iserdes_rst_o", shadow[8], 32'(iserdes_rst_o));
    check_word("mmcm_rst_o", 32'(shadow[9][0]), 32'(mmcm_rst_o));
    check_word("mmcm_clksel_o", 32'(shadow[9][8]), 32'(mmcm_clksel_o));
    check_word("snapshot_trigger_o", shadow[16], 32'(snapshot_trigger_o));
  endtask

  task automatic hold_level();
    repeat ($urandom_range(4, 2)) @(negedge wb_clk_i);
  endtask

  // k lclk edges before the fclk0 edge that closes the frame
  task automatic drive_frames(input int n);
    int  k;
    bit  f1;
    for (int f = 0; f < n; f++) begin
      k  = ($urandom_range(3, 0) == 0) ? 5 : 4;  // extra edge now and then
      f1 = 1'($urandom_range(1, 0));
      for (int e = 0; e < k; e++) begin
        lclk_i = 1'b1;
        hold_level();
        lclk_i = 1'b0;
        hold_level();
        exp_lclk++;
      end
      fclk_i = {f1, 1'b1};
      hold_level();
      fclk_i = '0;
      hold_level();
      exp_fclk[0]++;
      if (f1) exp_fclk[1]++;
      if (frame_seen && k != 4) exp_err++;
      frame_seen = 1'b1;
    end
  endtask

  task automatic print_counts();
    $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
  endtask

  initial begin
    #(TIMEOUT_NS);
    other_errs++;
    $display("timeout: the tests did not finish in the planned time");
    print_counts();
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [4:0]  a;
    int          start;
    void'($urandom(32'h41b60fda));
    wb_rst_i      = 1'b1;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    wb_sel_i      = 4'hf;
    wb_we_i       = 1'b0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    lclk_i        = 1'b0;
    fclk_i        = '0;
    mmcm_locked_i = 1'($urandom_range(1, 0));
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    shadow[4]   = 32'hffff_ffff;  // vt compensation on after reset
    shadow[5]   = 32'h7;
    exp_lclk    = '0;
    exp_err     = '0;
    exp_fclk[0] = '0;
    exp_fclk[1] = '0;
    frame_seen  = 1'b0;
    repeat (16) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    repeat (4) @(negedge wb_clk_i);

    // reset values of all 17 words in a shuffled order
    start = $urandom_range(16, 0);
    for (int i = 0; i < 17; i++) begin
      a = 5'((start + 7 * i) % 17);
      bus_read(a, rd);
      check_word($sformatf("wb_dat_o at reset, word %0d", a), expect_read(a), rd);
    end

    // round trip plus levels
    for (int i = 0; i < NUM_RT; i++) begin
      mmcm_locked_i = 1'($urandom_range(1, 0));  // synced well before the read below
      a  = 5'($urandom_range(31, 0));
      rd = $urandom();
      bus_write(a, rd);
      apply_write(a, rd);
      check_levels();
      a = 5'($urandom_range(31, 0));
      bus_read(a, rd);
      check_word($sformatf("wb_dat_o word %0d", a), expect_read(a), rd);
    end

    // pulse sequences on delay load and bitslip
    for (int i = 0; i < NUM_PULSE; i++) begin
      case ($urandom_range(2, 0))
        0:       a = 5'd0;
        1:       a = 5'd1;
        default: a = 5'd15;
      endcase
      rd = $urandom();
      bus_write(a, rd);
      apply_write(a, rd);
    end
    repeat (4) @(negedge wb_clk_i);
    for (int i = 0; i < DW; i++) check_pulses("delay_load_o", i, load_exp[i], load_seen[i]);
    for (int i = 0; i < SW; i++) check_pulses("bitslip_o", i, slip_exp[i], slip_seen[i]);

    // clock counts and frame errors read after 8 quiet cycles
    drive_frames(NUM_FRAMES);
    repeat (8) @(negedge wb_clk_i);
    bus_read(5'd10, rd);
    check_cnt("lclk_cnt", exp_lclk, cnt_t'(rd));
    bus_read(5'd11, rd);
    check_cnt("fclk0_cnt", exp_fclk[0], cnt_t'(rd));
    bus_read(5'd12, rd);
    check_cnt("fclk1_cnt", exp_fclk[1], cnt_t'(rd));
    bus_read(5'd13, rd);
    check_cnt("fclk2_cnt", cnt_t'(0), cnt_t'(rd));  // not built
    bus_read(5'd7, rd);
    check_cnt("fclk_err_cnt", exp_err, cnt_t'(rd));

    print_counts();
    if (val_errs == 0 && other_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- bench/ads5296_asserts.sv
`timescale 1ns/1ps

module ads5296_asserts import ads5296_pkg::*; #(
  parameter int NUM_UNITS = 4,
  parameter int NUM_FCLKS = 1
) (
  input logic                                   wb_clk_i,
  input logic                                   wb_rst_i,
  input logic                                   wb_ack_o,
  input logic                                   wb_err_o,
  input logic [31:0]                            wb_dat_o,
  input logic [dly_w(NUM_UNITS, NUM_FCLKS)-1:0] delay_load_o,
  input logic [slip_w(NUM_UNITS)-1:0]           bitslip_o
);

  // ack lasts one cycle, then a gap
  ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o) else $error("wb_ack_o high for two cycles");
  dat_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !wb_ack_o |-> wb_dat_o == 32'b0) else $error("wb_dat_o nonzero without ack");
  no_err: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !wb_err_o) else $error("wb_err_o raised");
  // pulses never stretch
  load_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (delay_load_o & $past(delay_load_o)) == '0) else $error("delay_load_o held");
  slip_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (bitslip_o & $past(bitslip_o)) == '0) else $error("bitslip_o held");

endmodule

bind ads5296_ctrl_top ads5296_asserts #(.NUM_UNITS(NUM_UNITS), .NUM_FCLKS(NUM_FCLKS))
  asserts_i (.wb_clk_i, .wb_rst_i, .wb_ack_o, .wb_err_o, .wb_dat_o, .delay_load_o, .bitslip_o);

//--- verilog/ads5296_ctrl_top.sv
`timescale 1ns/1ps

module ads5296_ctrl_top import ads5296_pkg::*; #(
  parameter int NUM_UNITS     = 4,
  parameter int NUM_FCLKS     = 1,
  parameter int IS_MASTER     = 0,
  parameter int LCLK_PER_FCLK = 4
) (
  input  logic                                   wb_clk_i,
  input  logic                                   wb_rst_i,
  input  logic [31:0]                            wb_adr_i,
  input  logic [31:0]                            wb_dat_i,
  input  logic [3:0]                             wb_sel_i,
  input  logic                                   wb_we_i,
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  output logic [31:0]                            wb_dat_o,
  output logic                                   wb_ack_o,
  output logic                                   wb_err_o,
  input  logic                                   lclk_i,
  input  logic [NUM_FCLKS-1:0]                   fclk_i,
  input  logic                                   mmcm_locked_i,
  output logic [dly_w(NUM_UNITS, NUM_FCLKS)-1:0] delay_load_o,
  output logic [dly_w(NUM_UNITS, NUM_FCLKS)-1:0] delay_rst_o,
  output logic [dly_w(NUM_UNITS, NUM_FCLKS)-1:0] delay_en_vtc_o,
  output logic [DLY_VAL_W-1:0]                   delay_val_o,
  output logic [slip_w(NUM_UNITS)-1:0]           bitslip_o,
  output logic                                   iserdes_rst_o,
  output logic                                   mmcm_rst_o,
  output logic                                   mmcm_clksel_o,
  output logic                                   snapshot_trigger_o
);

  ads5296_stat_if #(.NUM_FCLKS(NUM_FCLKS)) stat_if_i ();
  ads5296_ctrl_if #(.NUM_UNITS(NUM_UNITS), .NUM_FCLKS(NUM_FCLKS)) ctrl_if_i ();

  // line/frame clock sampling and error count
  ads5296_clk_monitor #(
    .NUM_FCLKS(NUM_FCLKS), .LCLK_PER_FCLK(LCLK_PER_FCLK)
  ) clk_monitor_i (
    .wb_clk_i, .wb_rst_i, .lclk_i, .fclk_i, .mmcm_locked_i,
    .stat(stat_if_i.mon)
  );

  wb_ads5296_attach #(
    .NUM_UNITS(NUM_UNITS), .NUM_FCLKS(NUM_FCLKS), .IS_MASTER(IS_MASTER)
  ) attach_i (
    .wb_clk_i, .wb_rst_i, .wb_adr_i, .wb_dat_i, .wb_sel_i, .wb_we_i,
    .wb_cyc_i, .wb_stb_i, .wb_dat_o, .wb_ack_o, .wb_err_o,
    .stat(stat_if_i.regs), .ctrl(ctrl_if_i.regs)
  );

  // levels to pulses toward idelay/iserdes
  ads5296_strobe_shaper #(
    .NUM_UNITS(NUM_UNITS), .NUM_FCLKS(NUM_FCLKS)
  ) shaper_i (
    .wb_clk_i, .wb_rst_i, .ctrl(ctrl_if_i.shaper),
    .delay_load_o, .delay_rst_o, .delay_en_vtc_o, .delay_val_o, .bitslip_o,
    .iserdes_rst_o, .mmcm_rst_o, .mmcm_clksel_o, .snapshot_trigger_o
  );

endmodule

//--- verilog/ads5296_strobe_shaper.sv
`timescale 1ns/1ps

module ads5296_strobe_shaper import ads5296_pkg::*; #(
  parameter int NUM_UNITS = 4,
  parameter int NUM_FCLKS = 1
) (
  input  logic                                 wb_clk_i,
  input  logic                                 wb_rst_i,
  ads5296_ctrl_if.shaper                       ctrl,
  output logic [dly_w(NUM_UNITS, NUM_FCLKS)-1:0] delay_load_o,  // pulses
  output logic [dly_w(NUM_UNITS, NUM_FCLKS)-1:0] delay_rst_o,
  output logic [dly_w(NUM_UNITS, NUM_FCLKS)-1:0] delay_en_vtc_o,
  output logic [DLY_VAL_W-1:0]                 delay_val_o,
  output logic [slip_w(NUM_UNITS)-1:0]         bitslip_o,     // pulses
  output logic                                 iserdes_rst_o,
  output logic                                 mmcm_rst_o,
  output logic                                 mmcm_clksel_o,
  output logic                                 snapshot_trigger_o
);

  logic [dly_w(NUM_UNITS, NUM_FCLKS)-1:0] load_prev_q;
  logic [slip_w(NUM_UNITS)-1:0]           slip_prev_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      load_prev_q        <= '0;
      slip_prev_q        <= '0;
      delay_load_o       <= '0;
      bitslip_o          <= '0;
      delay_rst_o        <= '0;
      delay_en_vtc_o     <= '1;  // matches register reset
      delay_val_o        <= '0;
      iserdes_rst_o      <= 1'b0;
      mmcm_rst_o         <= 1'b0;
      mmcm_clksel_o      <= 1'b0;
      snapshot_trigger_o <= 1'b0;
    end else begin
      load_prev_q  <= ctrl.delay_load;
      slip_prev_q  <= ctrl.bitslip;
      delay_load_o <= ctrl.delay_load & ~load_prev_q;  // rising level only
      bitslip_o    <= ctrl.bitslip & ~slip_prev_q;
      // plain levels, one flop of delay
      delay_rst_o        <= ctrl.delay_rst;
      delay_en_vtc_o     <= ctrl.delay_en_vtc;
      delay_val_o        <= ctrl.delay_val;
      iserdes_rst_o      <= ctrl.iserdes_rst;
      mmcm_rst_o         <= ctrl.mmcm_rst;
      mmcm_clksel_o      <= ctrl.mmcm_clksel;
      snapshot_trigger_o <= ctrl.snapshot_trigger;
    end
  end

endmodule

//--- verilog/wb_ads5296_attach.sv
`timescale 1ns/1ps

module wb_ads5296_attach import ads5296_pkg::*; #(
  parameter int NUM_UNITS = 4,  // map holds at most 4
  parameter int NUM_FCLKS = 1,
  parameter int IS_MASTER = 0
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,   // byte selects ignored, full words only
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  ads5296_stat_if.regs stat,
  ads5296_ctrl_if.regs ctrl
);

  localparam int LW = lane_w(NUM_UNITS);
  localparam int DW = dly_w(NUM_UNITS, NUM_FCLKS);
  localparam int SW = slip_w(NUM_UNITS);

  logic [4:0]           adr;
  logic                 accept;
  logic                 ack_q;
  logic [31:0]          rd_data;
  logic [31:0]          dat_q;    // read word, shown only with ack
  logic [DW-1:0]        delay_load_q;
  logic [DW-1:0]        delay_rst_q;
  logic [DW-1:0]        delay_en_vtc_q;
  logic [DLY_VAL_W-1:0] delay_val_q;
  logic [SW-1:0]        bitslip_q;
  logic                 iserdes_rst_q;
  logic                 mmcm_rst_q;
  logic                 mmcm_clksel_q;
  logic                 snapshot_q;

  assign adr    = wb_adr_i[6:2];
  assign accept = wb_stb_i & wb_cyc_i & ~ack_q;  // ack cycle blocks the next one

  // read mux, zero-extended
  always_comb begin
    rd_data = '0;
    case (adr)
      REG_DLY_LOAD_LO: rd_data = 32'(delay_load_q[LW-1:0]);
      REG_DLY_LOAD_HI: rd_data = 32'(delay_load_q[DW-1:LW]);
      REG_DLY_RST_LO:  rd_data = 32'(delay_rst_q[LW-1:0]);
      REG_DLY_RST_HI:  rd_data = 32'(delay_rst_q[DW-1:LW]);
      REG_DLY_VTC_LO:  rd_data = 32'(delay_en_vtc_q[LW-1:0]);
      REG_DLY_VTC_HI:  rd_data = 32'(delay_en_vtc_q[DW-1:LW]);
      REG_DLY_VAL:     rd_data = 32'(delay_val_q);
      REG_FCLK_ERR:    rd_data = stat.fclk_err_cnt;
      REG_ISERDES_RST: rd_data = 32'(iserdes_rst_q);
      REG_MMCM:        rd_data = {7'b0, 1'(IS_MASTER), 7'b0, stat.mmcm_locked,
                                  7'b0, mmcm_clksel_q, 7'b0, mmcm_rst_q};
      REG_LCLK_CNT:    rd_data = stat.lclk_cnt;
      REG_BITSLIP:     rd_data = 32'(bitslip_q);
      REG_SNAPSHOT:    rd_data = 32'(snapshot_q);
      default: ;
    endcase
    // unbuilt frame clocks stay zero
    for (int i = 0; i < NUM_FCLKS; i++) begin
      if (adr == REG_FCLK0_CNT + 5'(i)) rd_data = stat.fclk_cnt[i];
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q          <= 1'b0;
      delay_load_q   <= '0;
      delay_rst_q    <= '0;
      delay_en_vtc_q <= '1;  // vt compensation on out of reset
      delay_val_q    <= '0;
      bitslip_q      <= '0;
      iserdes_rst_q  <= 1'b0;
      mmcm_rst_q     <= 1'b0;
      mmcm_clksel_q  <= 1'b0;
      snapshot_q     <= 1'b0;
    end else begin
      ack_q <= accept;  // one cycle, then forced low
      if (accept && wb_we_i) begin
        case (adr)
          REG_DLY_LOAD_LO: delay_load_q[LW-1:0]    <= wb_dat_i[LW-1:0];
          REG_DLY_LOAD_HI: delay_load_q[DW-1:LW]   <= wb_dat_i[DW-LW-1:0];
          REG_DLY_RST_LO:  delay_rst_q[LW-1:0]     <= wb_dat_i[LW-1:0];
          REG_DLY_RST_HI:  delay_rst_q[DW-1:LW]    <= wb_dat_i[DW-LW-1:0];
          REG_DLY_VTC_LO:  delay_en_vtc_q[LW-1:0]  <= wb_dat_i[LW-1:0];
          REG_DLY_VTC_HI:  delay_en_vtc_q[DW-1:LW] <= wb_dat_i[DW-LW-1:0];
          REG_DLY_VAL:     delay_val_q             <= wb_dat_i[DLY_VAL_W-1:0];
          REG_ISERDES_RST: iserdes_rst_q           <= wb_dat_i[0];
          REG_MMCM: begin
            mmcm_rst_q    <= wb_dat_i[0];
            mmcm_clksel_q <= wb_dat_i[8];
          end
          REG_BITSLIP:     bitslip_q               <= wb_dat_i[SW-1:0];
          REG_SNAPSHOT:    snapshot_q              <= wb_dat_i[0];
          default: ;  // status and unmapped, acked and dropped
        endcase
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (accept && !wb_we_i) dat_q <= rd_data;
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = ack_q ? dat_q : 32'b0;
  assign wb_err_o = 1'b0;  // no error responses

  assign ctrl.delay_load       = delay_load_q;
  assign ctrl.delay_rst        = delay_rst_q;
  assign ctrl.delay_en_vtc     = delay_en_vtc_q;
  assign ctrl.delay_val        = delay_val_q;
  assign ctrl.bitslip          = bitslip_q;
  assign ctrl.iserdes_rst      = iserdes_rst_q;
  assign ctrl.mmcm_rst         = mmcm_rst_q;
  assign ctrl.mmcm_clksel      = mmcm_clksel_q;
  assign ctrl.snapshot_trigger = snapshot_q;

endmodule

//--- verilog/ads5296_clk_monitor.sv
`timescale 1ns/1ps

module ads5296_clk_monitor import ads5296_pkg::*; #(
  parameter int NUM_FCLKS     = 1,
  parameter int LCLK_PER_FCLK = 4
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 lclk_i,
  input  logic [NUM_FCLKS-1:0] fclk_i,
  input  logic                 mmcm_locked_i,
  ads5296_stat_if.mon          stat
);

  // lclk sits in the top bit, frame clocks below it
  localparam int NCLK = NUM_FCLKS + 1;
  localparam int LBIT = NUM_FCLKS;

  logic [NCLK-1:0] sync1_q;
  logic [NCLK-1:0] sync2_q;
  logic [NCLK-1:0] edge_q;   // last synced level
  logic [NCLK-1:0] rise;
  logic [1:0]      locked_q;
  cnt_t            lclk_in_frame_q;  // lclk edges since last fclk0 edge
  logic            frame_seen_q;     // first fclk0 edge only opens a frame

  assign rise             = sync2_q & ~edge_q;
  assign stat.mmcm_locked = locked_q[1];

  // two sync flops plus edge detect, so a count lands on the 3rd edge
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      sync1_q  <= '0;
      sync2_q  <= '0;
      edge_q   <= '0;
      locked_q <= '0;
    end else begin
      sync1_q  <= {lclk_i, fclk_i};
      sync2_q  <= sync1_q;
      edge_q   <= sync2_q;
      locked_q <= {locked_q[0], mmcm_locked_i};
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      stat.lclk_cnt     <= '0;
      stat.fclk_err_cnt <= '0;
      for (int i = 0; i < NUM_FCLKS; i++) stat.fclk_cnt[i] <= '0;
      lclk_in_frame_q   <= '0;
      frame_seen_q      <= 1'b0;
    end else begin
      if (rise[LBIT]) stat.lclk_cnt <= stat.lclk_cnt + 1'b1;
      for (int i = 0; i < NUM_FCLKS; i++) begin
        if (rise[i]) stat.fclk_cnt[i] <= stat.fclk_cnt[i] + 1'b1;
      end
      if (rise[0]) begin
        frame_seen_q <= 1'b1;
        if (frame_seen_q && lclk_in_frame_q != cnt_t'(LCLK_PER_FCLK))
          stat.fclk_err_cnt <= stat.fclk_err_cnt + 1'b1;  // misaligned frame
        // an lclk edge in the same cycle belongs to the new frame
        lclk_in_frame_q <= cnt_t'(rise[LBIT]);
      end else if (rise[LBIT]) begin
        lclk_in_frame_q <= lclk_in_frame_q + 1'b1;
      end
    end
  end

endmodule

//--- verilog/ads5296_ifs.sv
`timescale 1ns/1ps

// free-running status, monitor -> register file
interface ads5296_stat_if import ads5296_pkg::*; #(
  parameter int NUM_FCLKS = 1
);
  cnt_t lclk_cnt;
  cnt_t fclk_cnt [NUM_FCLKS];
  cnt_t fclk_err_cnt;  // frames with the wrong lclk count
  logic mmcm_locked;   // already synchronized

  modport mon  (output lclk_cnt, fclk_cnt, fclk_err_cnt, mmcm_locked);
  modport regs (input  lclk_cnt, fclk_cnt, fclk_err_cnt, mmcm_locked);
endinterface

// control levels, register file -> shaper
interface ads5296_ctrl_if import ads5296_pkg::*; #(
  parameter int NUM_UNITS = 4,
  parameter int NUM_FCLKS = 1
);
  localparam int DW = dly_w(NUM_UNITS, NUM_FCLKS);
  localparam int SW = slip_w(NUM_UNITS);

  logic [DW-1:0]        delay_load;    // shaped into pulses
  logic [DW-1:0]        delay_rst;
  logic [DW-1:0]        delay_en_vtc;
  logic [DLY_VAL_W-1:0] delay_val;
  logic [SW-1:0]        bitslip;       // shaped into pulses
  logic                 iserdes_rst;
  logic                 mmcm_rst;
  logic                 mmcm_clksel;
  logic                 snapshot_trigger;

  modport regs (output delay_load, delay_rst, delay_en_vtc, delay_val, bitslip,
                       iserdes_rst, mmcm_rst, mmcm_clksel, snapshot_trigger);
  modport shaper (input delay_load, delay_rst, delay_en_vtc, delay_val, bitslip,
                        iserdes_rst, mmcm_rst, mmcm_clksel, snapshot_trigger);
endinterface

//--- verilog/ads5296_pkg.sv
package ads5296_pkg;

  // status counters, all wrap freely
  typedef logic [31:0] cnt_t;

  // word addresses, taken from adr[6:2]
  localparam logic [4:0] REG_DLY_LOAD_LO = 5'd0;
  localparam logic [4:0] REG_DLY_LOAD_HI = 5'd1;
  localparam logic [4:0] REG_DLY_RST_LO  = 5'd2;
  localparam logic [4:0] REG_DLY_RST_HI  = 5'd3;
  localparam logic [4:0] REG_DLY_VTC_LO  = 5'd4;
  localparam logic [4:0] REG_DLY_VTC_HI  = 5'd5;
  localparam logic [4:0] REG_DLY_VAL     = 5'd6;
  localparam logic [4:0] REG_FCLK_ERR    = 5'd7;   // read only
  localparam logic [4:0] REG_ISERDES_RST = 5'd8;
  localparam logic [4:0] REG_MMCM        = 5'd9;
  localparam logic [4:0] REG_LCLK_CNT    = 5'd10;  // read only
  localparam logic [4:0] REG_FCLK0_CNT   = 5'd11;  // 11..14 read only
  localparam logic [4:0] REG_FCLK3_CNT   = 5'd14;
  localparam logic [4:0] REG_BITSLIP     = 5'd15;
  localparam logic [4:0] REG_SNAPSHOT    = 5'd16;

  localparam int DLY_VAL_W = 9;  // idelay tap value

  // data lanes, 8 per unit
  function automatic int lane_w(input int num_units);
    return 8 * num_units;
  endfunction

  // lanes + frame clocks + the sync_out lane
  function automatic int dly_w(input int num_units, input int num_fclks);
    return lane_w(num_units) + num_fclks + 1;
  endfunction

  function automatic int slip_w(input int num_units);
    return 4 * num_units;  // one per iserdes
  endfunction

endpackage
